// File: common/ex_pkg.sv
// Execute stage package
// Operator encodings for the ALU and the multiplier, plus the
// widths that the execute-stage blocks share

package ex_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Register file address, one spare bit above the 32 GPRs
  localparam int REG_ADDR_W = 6;

  // Datapath width unless the top level overrides it
  localparam int DATA_W_DEFAULT = 32;

  //////////////////////////////////////////////////
  // ALU operators
  //////////////////////////////////////////////////

  typedef enum logic [4:0] {
    // Adder group
    ALU_ADD  = 5'b00000,
    ALU_SUB  = 5'b00001,
    // Bitwise logic
    ALU_AND  = 5'b00100,
    ALU_OR   = 5'b00101,
    ALU_XOR  = 5'b00110,
    // Shifts share one right shifter
    ALU_SLL  = 5'b01000,
    ALU_SRL  = 5'b01001,
    ALU_SRA  = 5'b01010,
    // Set-less-than writes the compare bit to rd
    ALU_SLT  = 5'b01100,
    ALU_SLTU = 5'b01101,
    // Branch comparisons only drive the compare output
    ALU_EQ   = 5'b10000,
    ALU_NE   = 5'b10001,
    ALU_LT   = 5'b10010,
    ALU_GE   = 5'b10011,
    ALU_LTU  = 5'b10100,
    ALU_GEU  = 5'b10101
  } alu_op_e;

  //////////////////////////////////////////////////
  // Multiplier operators
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    MUL_L   = 2'b00,
    MUL_H   = 2'b01,
    MUL_HU  = 2'b10,
    MUL_HSU = 2'b11
  } mul_op_e;

endpackage

// File: logic/ex_alu.sv
// Integer ALU of the execute stage
// Add, subtract, bitwise logic, shifts and set-less-than on result_o,
// branch comparisons on cmp_result_o; purely combinational

`timescale 1ns/1ps

module ex_alu
  import ex_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEFAULT
) (
  input  alu_op_e           operator_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  output logic [DATA_W-1:0] result_o,
  output logic              cmp_result_o
);

  localparam int SHAMT_W = $clog2(DATA_W);

  logic                     adder_sub;
  logic [DATA_W-1:0]        adder_b;
  logic [DATA_W:0]          adder_sum;
  logic                     is_equal;
  logic                     lt_signed;
  logic                     lt_unsigned;
  logic                     shift_left;
  logic                     shift_fill;
  logic [SHAMT_W-1:0]       shamt;
  logic [DATA_W-1:0]        shift_in;
  logic signed [DATA_W:0]   shift_ext;
  logic [DATA_W-1:0]        shift_right;
  logic [DATA_W-1:0]        shift_result;

  // Mirror a word so that a left shift can use the right shifter
  function automatic logic [DATA_W-1:0] bit_rev(input logic [DATA_W-1:0] v);
    logic [DATA_W-1:0] r;
    for (int i = 0; i < DATA_W; i++) begin
      r[i] = v[DATA_W-1-i];
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////

  // Everything but ADD subtracts, compares included
  assign adder_sub = (operator_i != ALU_ADD);
  assign adder_b   = adder_sub ? ~operand_b_i : operand_b_i;
  // Carry-in of one completes the two's complement of b
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b} + {{DATA_W{1'b0}}, adder_sub};

  // Borrow out means a < b unsigned
  assign lt_unsigned = ~adder_sum[DATA_W];
  // Differing signs decide directly, else the sign of a - b
  assign lt_signed   = (operand_a_i[DATA_W-1] != operand_b_i[DATA_W-1]) ?
                       operand_a_i[DATA_W-1] : adder_sum[DATA_W-1];
  assign is_equal    = (adder_sum[DATA_W-1:0] == '0);

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  assign shift_left = (operator_i == ALU_SLL);
  assign shamt      = operand_b_i[SHAMT_W-1:0];
  assign shift_in   = shift_left ? bit_rev(operand_a_i) : operand_a_i;
  // Extra top bit carries the sign for SRA, zero otherwise
  assign shift_fill = (operator_i == ALU_SRA) & operand_a_i[DATA_W-1];
  assign shift_ext  = $signed({shift_fill, shift_in}) >>> shamt;

  assign shift_right  = shift_ext[DATA_W-1:0];
  assign shift_result = shift_left ? bit_rev(shift_right) : shift_right;

  // Comparison select, shared by branches and set-less-than
  always_comb begin
    case (operator_i)
      ALU_EQ:            cmp_result_o = is_equal;
      ALU_NE:            cmp_result_o = ~is_equal;
      ALU_LT, ALU_SLT:   cmp_result_o = lt_signed;
      ALU_GE:            cmp_result_o = ~lt_signed;
      ALU_LTU, ALU_SLTU: cmp_result_o = lt_unsigned;
      ALU_GEU:           cmp_result_o = ~lt_unsigned;
      default:           cmp_result_o = 1'b0;
    endcase
  end

  // Result select
  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB:          result_o = adder_sum[DATA_W-1:0];
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      // Compare bit zero-extended
      ALU_SLT, ALU_SLTU:         result_o = {{(DATA_W-1){1'b0}}, cmp_result_o};
      // Branch compares leave the result at zero
      default:                   result_o = '0;
    endcase
  end

endmodule

// File: logic/ex_mult.sv
// Integer multiplier of the execute stage
// MUL_L gives the low product in the same cycle; the high-word
// operators build the double-width product from two half-width
// partial products and finish in the third cycle

`timescale 1ns/1ps

module ex_mult
  import ex_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEFAULT
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  mul_op_e           operator_i,
  input  logic [DATA_W-1:0] op_a_i,
  input  logic [DATA_W-1:0] op_b_i,
  input  logic              ex_ready_i,
  output logic [DATA_W-1:0] result_o,
  output logic              multicycle_o,
  output logic              ready_o
);

  localparam int HALF_W = DATA_W / 2;

  typedef enum logic [1:0] {MULH_IDLE, MULH_STEP, MULH_FINISH} mulh_state_e;

  mulh_state_e                     state_q;
  mulh_state_e                     state_d;
  logic                            is_high;
  logic                            a_signed;
  logic                            b_signed;
  logic signed [DATA_W:0]          a_ext;
  logic signed [DATA_W:0]          b_ext;
  logic signed [HALF_W:0]          b_part;
  logic signed [DATA_W+HALF_W+1:0] part_prod;
  logic signed [2*DATA_W-1:0]      part_ext;
  logic [2*DATA_W-1:0]             acc_q;
  logic [DATA_W-1:0]               prod_lo;

  // Low word is the same for signed and unsigned operands
  assign prod_lo = op_a_i * op_b_i;

  // Operand extension per operator
  assign is_high  = (operator_i != MUL_L);
  assign a_signed = (operator_i == MUL_H) | (operator_i == MUL_HSU);
  assign b_signed = (operator_i == MUL_H);
  assign a_ext    = {a_signed & op_a_i[DATA_W-1], op_a_i};
  assign b_ext    = {b_signed & op_b_i[DATA_W-1], op_b_i};

  // Low half of b first as unsigned, then the signed upper half
  assign b_part    = (state_q == MULH_IDLE) ? {1'b0, b_ext[HALF_W-1:0]} :
                                              b_ext[DATA_W:HALF_W];
  assign part_prod = a_ext * b_part;
  assign part_ext  = part_prod;

  //////////////////////////////////////////////////
  // High-word FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    ready_o = 1'b1;
    case (state_q)
      MULH_IDLE: begin
        if (enable_i && is_high) begin
          ready_o = 1'b0;
          state_d = MULH_STEP;
        end
      end
      MULH_STEP: begin
        ready_o = 1'b0;
        state_d = MULH_FINISH;
      end
      // High word valid, leave once the stage moves on
      MULH_FINISH: begin
        if (ex_ready_i) begin
          state_d = MULH_IDLE;
        end
      end
      default: state_d = MULH_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Accumulator: load low partial, then add the shifted upper partial
  always_ff @(posedge clk) begin
    if ((state_q == MULH_IDLE) && enable_i && is_high) begin
      acc_q <= part_ext;
    end else if (state_q == MULH_STEP) begin
      acc_q <= acc_q + (part_ext <<< HALF_W);
    end
  end

  assign multicycle_o = (state_q == MULH_FINISH);
  assign result_o     = multicycle_o ? acc_q[2*DATA_W-1:DATA_W] : prod_lo;

endmodule

// File: ex_stage/ex_wb_ctrl.sv
// Writeback and stage control of the execute stage
// Forwarding-port mux toward ID, EX/WB register for load results,
// and the stage ready/valid strobes

`timescale 1ns/1ps

module ex_wb_ctrl
  import ex_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Unit enables from ID
  input  logic                  alu_en_i,
  input  logic                  mult_en_i,
  input  logic                  csr_access_i,
  input  logic                  lsu_en_i,
  // Unit results
  input  logic [DATA_W-1:0]     alu_result_i,
  input  logic [DATA_W-1:0]     mult_result_i,
  input  logic [DATA_W-1:0]     csr_rdata_i,
  // Stall sources
  input  logic                  mult_ready_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,
  input  logic                  wb_ready_i,
  input  logic                  branch_in_ex_i,
  // Destination info from ID
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic [DATA_W-1:0]     lsu_rdata_i,
  // Forwarding port
  output logic                  regfile_alu_we_fw_o,
  output logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [DATA_W-1:0]     regfile_alu_wdata_fw_o,
  // Load writeback port
  output logic                  regfile_we_wb_o,
  output logic [REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [DATA_W-1:0]     regfile_wdata_wb_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic units_ready;

  // Forwarding data by priority: CSR, then multiplier, then ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  //////////////////////////////////////////////////
  // EX/WB load register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end else if (ex_valid_o) begin
      // A bus error kills the load write
      regfile_we_wb_o <= regfile_we_i & ~lsu_err_i;
      if (regfile_we_i && !lsu_err_i) begin
        regfile_waddr_wb_o <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Bubble: WB drains the slot
      regfile_we_wb_o <= 1'b0;
    end
  end

  // Load data arrives in WB, straight from the LSU
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Stage strobes; a branch resolves here and never waits on WB
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

// File: ex_stage/ex_stage.sv
// Execute stage top level
// Hosts the ALU, the multiplier and the writeback/stage control,
// and passes the branch decision and jump target to fetch

`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // ALU operation from ID
  input  logic                  alu_en_i,
  input  alu_op_e               alu_operator_i,
  input  logic [DATA_W-1:0]     alu_operand_a_i,
  input  logic [DATA_W-1:0]     alu_operand_b_i,
  input  logic [DATA_W-1:0]     alu_operand_c_i,
  // Multiplier operation from ID
  input  logic                  mult_en_i,
  input  mul_op_e               mult_operator_i,
  input  logic [DATA_W-1:0]     mult_operand_a_i,
  input  logic [DATA_W-1:0]     mult_operand_b_i,
  // CSR read
  input  logic                  csr_access_i,
  input  logic [DATA_W-1:0]     csr_rdata_i,
  // Destinations
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  // LSU
  input  logic                  lsu_en_i,
  input  logic [DATA_W-1:0]     lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,
  input  logic                  branch_in_ex_i,
  input  logic                  wb_ready_i,
  // Forwarding port to ID
  output logic                  regfile_alu_we_fw_o,
  output logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [DATA_W-1:0]     regfile_alu_wdata_fw_o,
  // Load port to WB
  output logic                  regfile_we_wb_o,
  output logic [REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [DATA_W-1:0]     regfile_wdata_wb_o,
  // To fetch
  output logic [DATA_W-1:0]     jump_target_o,
  output logic                  branch_decision_o,
  output logic                  mult_multicycle_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic [DATA_W-1:0] alu_result;
  logic              alu_cmp_result;
  logic [DATA_W-1:0] mult_result;
  logic              mult_ready;

  // Branch outcome goes to fetch unregistered
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ex_alu #(.DATA_W(DATA_W)) alu_i (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Stage ready releases the high-word FSM from its final state
  ex_mult #(.DATA_W(DATA_W)) mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_wb_ctrl #(.DATA_W(DATA_W)) wb_ctrl_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// File: testbench/tb_ex_stage.sv
// Testbench for the execute stage
// Replays the golden vector file against the DUT, one vector per line.
// Inputs change on the falling edge; combinational outputs are checked
// inside the cycle, the EX/WB load register after the next rising edge

`timescale 1ns/1ps

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int    DATA_W       = 32;
  localparam int    CLK_PERIOD   = 100;
  localparam int    RESET_CYCLES = 8;
  localparam int    MAX_STALL    = 16;
  localparam string VEC_FILE     = "testbench/ex_golden.txt";

  logic                  clk;
  logic                  rst_n;
  logic                  alu_en_i;
  alu_op_e               alu_operator_i;
  logic [DATA_W-1:0]     alu_operand_a_i;
  logic [DATA_W-1:0]     alu_operand_b_i;
  logic [DATA_W-1:0]     alu_operand_c_i;
  logic                  mult_en_i;
  mul_op_e               mult_operator_i;
  logic [DATA_W-1:0]     mult_operand_a_i;
  logic [DATA_W-1:0]     mult_operand_b_i;
  logic                  csr_access_i;
  logic [DATA_W-1:0]     csr_rdata_i;
  logic                  regfile_alu_we_i;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i;
  logic                  regfile_we_i;
  logic [REG_ADDR_W-1:0] regfile_waddr_i;
  logic                  lsu_en_i;
  logic [DATA_W-1:0]     lsu_rdata_i;
  logic                  lsu_ready_ex_i;
  logic                  lsu_err_i;
  logic                  branch_in_ex_i;
  logic                  wb_ready_i;
  logic                  regfile_alu_we_fw_o;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw_o;
  logic [DATA_W-1:0]     regfile_alu_wdata_fw_o;
  logic                  regfile_we_wb_o;
  logic [REG_ADDR_W-1:0] regfile_waddr_wb_o;
  logic [DATA_W-1:0]     regfile_wdata_wb_o;
  logic [DATA_W-1:0]     jump_target_o;
  logic                  branch_decision_o;
  logic                  mult_multicycle_o;
  logic                  ex_ready_o;
  logic                  ex_valid_o;

  string       vec_lines[$];
  int          errors      = 0;
  int          checks      = 0;
  int unsigned cycle_limit = 0;
  int unsigned cycle_count = 0;

  ex_stage #(.DATA_W(DATA_W)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Watchdog whose limit is known once the vectors are loaded
  initial begin
    while (cycle_limit == 0 || cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles with %0d checks and %0d errors so far",
             cycle_count, checks, errors);
    $display("Regression failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("MISMATCH %s %s: expected 0x%h, actual 0x%h", test, field, expected, actual);
      errors++;
    end
  endtask

  // Quiet bus with nothing enabled and LSU and WB ready
  task automatic drive_idle();
    {alu_en_i, mult_en_i, csr_access_i, lsu_en_i} = 4'b0000;
    {regfile_alu_we_i, regfile_we_i, lsu_err_i, branch_in_ex_i} = 4'b0000;
    lsu_ready_ex_i      = 1'b1;
    wb_ready_i          = 1'b1;
    alu_operator_i      = ALU_ADD;
    mult_operator_i     = MUL_L;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    csr_rdata_i         = '0;
    lsu_rdata_i         = '0;
    regfile_alu_waddr_i = '0;
    regfile_waddr_i     = '0;
  endtask

  // Keep the vector lines and skip comments and blank lines
  task automatic load_vectors();
    int    fd;
    int    code;
    string line;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", VEC_FILE);
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          vec_lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    if (vec_lines.size() == 0) begin
      $display("The vector file holds no vectors");
      errors++;
    end
    cycle_limit = vec_lines.size() * 4 + 40;
  endtask

  //////////////////////////////////////////////////
  // Drive one vector, wait out stalls and check
  //////////////////////////////////////////////////

  // Called on a falling edge and returns on the next falling edge after the result
  task automatic run_vector(input string line);
    string       name;
    logic [31:0] ctrl, aop, opa, opb, opc, mop, csr, rdata, fwa, wba;
    logic [31:0] exp_fw, exp_flags, exp_wba, exp_stalls;
    int          fields;
    int          stalls;
    fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name, ctrl,
                     aop, opa, opb, opc, mop, csr, rdata, fwa, wba, exp_fw, exp_flags,
                     exp_wba, exp_stalls);
    if (fields != 15) begin
      $display("Malformed vector line, %0d fields read: %s", fields, line);
      errors++;
      return;
    end
    // Control word from bit 0 upward
    {wb_ready_i, branch_in_ex_i, lsu_err_i, lsu_ready_ex_i} = ctrl[9:6];
    {regfile_we_i, regfile_alu_we_i, lsu_en_i} = ctrl[5:3];
    {csr_access_i, mult_en_i, alu_en_i} = ctrl[2:0];
    alu_operator_i      = alu_op_e'(aop[4:0]);
    mult_operator_i     = mul_op_e'(mop[1:0]);
    // ALU and multiplier see the same operand pair
    alu_operand_a_i     = opa;
    alu_operand_b_i     = opb;
    mult_operand_a_i    = opa;
    mult_operand_b_i    = opb;
    alu_operand_c_i     = opc;
    csr_rdata_i         = csr;
    lsu_rdata_i         = rdata;
    regfile_alu_waddr_i = fwa[REG_ADDR_W-1:0];
    regfile_waddr_i     = wba[REG_ADDR_W-1:0];
    #(CLK_PERIOD/10);
    // High-word multiply holds its inputs while the stage stalls
    stalls = 0;
    if (exp_stalls != 0) begin
      while (!ex_ready_o && stalls < MAX_STALL) begin
        stalls++;
        @(negedge clk);
        #(CLK_PERIOD/10);
      end
      checks++;
      assert (ex_ready_o) else begin
        $display("%s: ex_ready_o stayed low for %0d cycles and never rose", name, stalls);
        errors++;
      end
      check_value(name, "stall cycles", exp_stalls, stalls);
    end
    check_value(name, "fw data", exp_fw, regfile_alu_wdata_fw_o);
    check_value(name, "fw we", exp_flags[0], regfile_alu_we_fw_o);
    check_value(name, "fw addr", fwa, regfile_alu_waddr_fw_o);
    check_value(name, "branch", exp_flags[1], branch_decision_o);
    check_value(name, "jump target", opc, jump_target_o);
    check_value(name, "ex_ready", exp_flags[3], ex_ready_o);
    check_value(name, "ex_valid", exp_flags[4], ex_valid_o);
    check_value(name, "multicycle", exp_flags[5], mult_multicycle_o);
    // Load register after the rising edge
    @(negedge clk);
    check_value(name, "wb we", exp_flags[2], regfile_we_wb_o);
    check_value(name, "wb addr", exp_wba, regfile_waddr_wb_o);
    check_value(name, "wb data", rdata, regfile_wdata_wb_o);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    drive_idle();
    load_vectors();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    #(CLK_PERIOD/10);
    // Reset values with the bus idle
    check_value("reset", "wb we", 1'b0, regfile_we_wb_o);
    check_value("reset", "wb addr", '0, regfile_waddr_wb_o);
    check_value("reset", "multicycle", 1'b0, mult_multicycle_o);
    check_value("reset", "ex_ready", 1'b1, ex_ready_o);
    @(negedge clk);
    foreach (vec_lines[i]) begin
      run_vector(vec_lines[i]);
    end
    $display("Vectors: %0d, checks: %0d, errors: %0d", vec_lines.size(), checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: testbench/ex_golden.txt
# name ctrl aop opa opb opc mop csr_rdata lsu_rdata fw_addr wb_addr | exp_fw flags wb_addr stalls
# ctrl bits 0..9: alu_en mult_en csr lsu_en alu_we we lsu_ready lsu_err branch wb_ready
# flags bits 0..5: fw_we branch wb_we ex_ready ex_valid multicycle; all fields hex
add_basic      251 00 12345678 11111111 00000000 0 00000000 00000000 05 00 23456789 19 00 0
add_wrap       251 00 ffffffff 00000002 00000000 0 00000000 00000000 06 00 00000001 19 00 0
sub_basic      251 01 00000005 00000007 00000000 0 00000000 00000000 07 00 fffffffe 19 00 0
and_mask       251 04 f0f0ff00 ff00f0f0 00000000 0 00000000 00000000 08 00 f000f000 19 00 0
or_mask        251 05 f0f0ff00 ff00f0f0 00000000 0 00000000 00000000 09 00 fff0fff0 19 00 0
xor_mask       251 06 f0f0ff00 ff00f0f0 00000000 0 00000000 00000000 0a 00 0ff00ff0 19 00 0
sll_basic      251 08 80000001 00000004 00000000 0 00000000 00000000 0b 00 00000010 19 00 0
sll_max        251 08 00000003 0000003f 00000000 0 00000000 00000000 0c 00 80000000 19 00 0
srl_basic      251 09 80000000 00000003 00000000 0 00000000 00000000 0d 00 10000000 19 00 0
sra_neg        251 0a 80000000 00000003 00000000 0 00000000 00000000 0e 00 f0000000 19 00 0
sra_pos        251 0a 7ffffff0 00000024 00000000 0 00000000 00000000 0f 00 07ffffff 19 00 0
slt_true       251 0c ffffffff 00000001 00000000 0 00000000 00000000 10 00 00000001 1b 00 0
slt_false      251 0c 00000001 ffffffff 00000000 0 00000000 00000000 11 00 00000000 19 00 0
slt_ovf        251 0c 80000000 00000001 00000000 0 00000000 00000000 12 00 00000001 1b 00 0
sltu_true      251 0d 00000001 ffffffff 00000000 0 00000000 00000000 13 00 00000001 1b 00 0
sltu_false     251 0d ffffffff 00000001 00000000 0 00000000 00000000 14 00 00000000 19 00 0
beq_taken      341 10 0000abcd 0000abcd 00001000 0 00000000 00000000 00 00 00000000 1a 00 0
beq_not        341 10 0000abcd 0000abce 00001004 0 00000000 00000000 00 00 00000000 18 00 0
bne_taken      341 11 00000001 00000002 00002040 0 00000000 00000000 00 00 00000000 1a 00 0
blt_taken      341 12 fffffff0 00000010 00003000 0 00000000 00000000 00 00 00000000 1a 00 0
bge_taken      341 13 00000010 fffffff0 00003ffc 0 00000000 00000000 00 00 00000000 1a 00 0
bge_equal      341 13 80000000 80000000 80000000 0 00000000 00000000 00 00 00000000 1a 00 0
bltu_not       341 14 fffffff0 00000010 00004008 0 00000000 00000000 00 00 00000000 18 00 0
bgeu_taken     341 15 fffffff0 00000010 0000500c 0 00000000 00000000 00 00 00000000 1a 00 0
branch_wb_low  141 10 00000022 00000022 00006000 0 00000000 00000000 00 00 00000000 0a 00 0
mul_low        252 00 00001234 00005678 00000000 0 00000000 00000000 15 00 06260060 19 00 0
mul_low_wrap   252 00 ffffffff ffffffff 00000000 0 00000000 00000000 16 00 00000001 19 00 0
mulh_neg       252 00 ffffffff 00000002 00000000 1 00000000 00000000 17 00 ffffffff 39 00 2
mulhu_max      252 00 ffffffff ffffffff 00000000 2 00000000 00000000 18 00 fffffffe 39 00 2
mulhsu_neg     252 00 ffffffff ffffffff 00000000 3 00000000 00000000 19 00 ffffffff 39 00 2
mulh_pos       252 00 12345678 10000000 00000000 1 00000000 00000000 1a 00 01234567 39 00 2
mulh_min       252 00 80000000 80000000 00000000 1 00000000 00000000 1b 00 40000000 39 00 2
csr_over_mult  257 00 00000003 00000004 00000000 0 cafef00d 00000000 1c 00 cafef00d 19 00 0
mult_over_alu  253 00 00000003 00000004 00000000 0 00000000 00000000 1d 00 0000000c 19 00 0
csr_over_alu   255 00 00000003 00000004 00000000 0 00c0ffee 00000000 1e 00 00c0ffee 19 00 0
load_write     268 00 00000000 00000000 00000000 0 00000000 deadbeef 00 0a 00000000 1c 0a 0
load_err       2e8 00 00000000 00000000 00000000 0 00000000 12345678 00 0b 00000000 18 0a 0
load_write2    268 00 00000000 00000000 00000000 0 00000000 0badf00d 00 1f 00000000 1c 1f 0
wb_hold        040 00 00000000 00000000 00000000 0 00000000 11112222 00 00 00000000 04 1f 0
wb_hold_again  040 00 00000000 00000000 00000000 0 00000000 33334444 00 00 00000000 04 1f 0
wb_drain       240 00 00000000 00000000 00000000 0 00000000 00000000 00 00 00000000 08 1f 0
lsu_stall      228 00 00000000 00000000 00000000 0 00000000 55555555 00 05 00000000 00 1f 0
load_resume    268 00 00000000 00000000 00000000 0 00000000 55aa55aa 00 05 00000000 1c 05 0
idle_end       240 00 00000000 00000000 00000000 0 00000000 00000000 00 00 00000000 08 05 0

// File: flist.f
common/ex_pkg.sv
logic/ex_alu.sv
logic/ex_mult.sv
ex_stage/ex_wb_ctrl.sv
ex_stage/ex_stage.sv
testbench/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
# Build and run the execute-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ex_stage -f flist.f -o tb_ex_stage

./obj_dir/tb_ex_stage > sim.log
cat sim.log

if grep -q "Regression passed" sim.log; then
  exit 0
else
  exit 1
fi
